// File: source/io_config.svh
`ifndef IO_CONFIG_SVH
`define IO_CONFIG_SVH

// --------------------
// widths
// --------------------
`define IO_DATA_BITS 32 // data and address
`define IO_KEY_BITS 4
`define IO_SW_BITS 10
`define IO_LED_BITS 10
`define IO_HEX_BITS 24 // six digits

// --------------------
// address map
// --------------------
`define IO_ADDR_HEX 32'hFFFF_F000
`define IO_ADDR_LEDR 32'hFFFF_F020
`define IO_ADDR_KEY 32'hFFFF_F080
`define IO_ADDR_SW 32'hFFFF_F090
`define IO_ADDR_TIMER 32'hFFFF_F100

`define IO_CTRL_OFFSET 32'd4 // key and switch control
`define IO_TIMER_LIM_OFFSET 32'd4
`define IO_TIMER_CTRL_OFFSET 32'd8

// status bit positions in a control register
`define IO_CTRL_RDY_BIT 0
`define IO_CTRL_OVR_BIT 1
`define IO_CTRL_IE_BIT 4

// kept short for simulation
`define IO_SW_SETTLE 8 // stable cycles before a switch capture
`define IO_TIMER_PRESCALE 4 // clocks per timer tick

`endif

// File: source/io_pkg.sv
`include "io_config.svh"

package io_pkg;

  // request from the bus master, one cycle per strobe
  typedef struct packed {
    logic                     valid;
    logic                     write;
    logic [`IO_DATA_BITS-1:0] addr;
    logic [`IO_DATA_BITS-1:0] wdata;
  } bus_req_t;

  // read response, one cycle after the read
  typedef struct packed {
    logic                     valid;
    logic [`IO_DATA_BITS-1:0] rdata;
  } bus_rsp_t;

  typedef struct packed {
    logic ie;
    logic overrun;
    logic ready;
  } dev_status_t;

  typedef enum logic [1:0] {
    DEV_TIMER = 2'd0,
    DEV_KEY   = 2'd1,
    DEV_SW    = 2'd2
  } dev_id_t;

  typedef enum logic [3:0] {
    SEL_NONE,
    SEL_HEX,
    SEL_LED,
    SEL_KEY_DATA,
    SEL_KEY_CTRL,
    SEL_SW_DATA,
    SEL_SW_CTRL,
    SEL_TMR_CNT,
    SEL_TMR_LIM,
    SEL_TMR_CTRL
  } reg_sel_t;

  // common status update, an event wins over a read clear
  function automatic dev_status_t status_next(
    input dev_status_t              cur,
    input logic                     evt,
    input logic                     data_rd,
    input logic                     ctrl_wr,
    input logic [`IO_DATA_BITS-1:0] wdata
  );
    dev_status_t nxt;
    nxt = cur;
    if (ctrl_wr) begin
      nxt.ie = wdata[`IO_CTRL_IE_BIT];
      if (!wdata[`IO_CTRL_OVR_BIT])
        nxt.overrun = 1'b0; // writing 0 clears overrun
    end
    if (evt) begin
      if (cur.ready)
        nxt.overrun = 1'b1; // previous event never read
      nxt.ready = 1'b1;
    end else if (data_rd) begin
      nxt.ready = 1'b0;
    end
    return nxt;
  endfunction

endpackage

// File: source/io_bus_fabric.sv
`timescale 1ns/1ns
`include "io_config.svh"

module io_bus_fabric (
  input  logic                     clk,
  input  logic                     reset,
  input  io_pkg::bus_req_t         req,
  output io_pkg::bus_rsp_t         rsp,
  output logic [`IO_DATA_BITS-1:0] wr_data,
  output logic                     hex_wr,
  output logic                     led_wr,
  output logic                     key_ctrl_wr,
  output logic                     sw_ctrl_wr,
  output logic                     tmr_cnt_wr,
  output logic                     tmr_lim_wr,
  output logic                     tmr_ctrl_wr,
  output logic                     key_data_rd,
  output logic                     sw_data_rd,
  input  logic [`IO_HEX_BITS-1:0]  hex_value,
  input  logic [`IO_LED_BITS-1:0]  led_value,
  input  logic [`IO_KEY_BITS-1:0]  key_data,
  input  io_pkg::dev_status_t      key_status,
  input  logic [`IO_SW_BITS-1:0]   sw_data,
  input  io_pkg::dev_status_t      sw_status,
  input  logic [`IO_DATA_BITS-1:0] tmr_count,
  input  logic [`IO_DATA_BITS-1:0] tmr_limit,
  input  io_pkg::dev_status_t      tmr_status,
  output logic                     irq,
  output io_pkg::dev_id_t          irq_id
);
  import io_pkg::*;

  localparam int DW = `IO_DATA_BITS;

  reg_sel_t      sel;
  logic          wr_en;
  logic          rd_en;
  logic [DW-1:0] rd_value;
  logic          rsp_valid;
  logic [DW-1:0] rsp_data;
  logic          tmr_irq;
  logic          key_irq;
  logic          sw_irq;

  // status bits as seen in a control register
  function automatic logic [DW-1:0] ctrl_word(input dev_status_t s);
    logic [DW-1:0] w;
    w = '0;
    w[`IO_CTRL_RDY_BIT] = s.ready;
    w[`IO_CTRL_OVR_BIT] = s.overrun;
    w[`IO_CTRL_IE_BIT]  = s.ie;
    return w;
  endfunction

  // --------------------
  // decode
  // --------------------
  always_comb begin
    sel = SEL_NONE;
    if (req.valid) begin
      case (req.addr)
        `IO_ADDR_HEX:                           sel = SEL_HEX;
        `IO_ADDR_LEDR:                          sel = SEL_LED;
        `IO_ADDR_KEY:                           sel = SEL_KEY_DATA;
        `IO_ADDR_KEY + `IO_CTRL_OFFSET:         sel = SEL_KEY_CTRL;
        `IO_ADDR_SW:                            sel = SEL_SW_DATA;
        `IO_ADDR_SW + `IO_CTRL_OFFSET:          sel = SEL_SW_CTRL;
        `IO_ADDR_TIMER:                         sel = SEL_TMR_CNT;
        `IO_ADDR_TIMER + `IO_TIMER_LIM_OFFSET:  sel = SEL_TMR_LIM;
        `IO_ADDR_TIMER + `IO_TIMER_CTRL_OFFSET: sel = SEL_TMR_CTRL;
        default:                                sel = SEL_NONE; // unmapped
      endcase
    end
  end

  assign wr_en   = req.valid & req.write;
  assign rd_en   = req.valid & ~req.write;
  assign wr_data = req.wdata;

  assign hex_wr      = wr_en && (sel == SEL_HEX);
  assign led_wr      = wr_en && (sel == SEL_LED);
  assign key_ctrl_wr = wr_en && (sel == SEL_KEY_CTRL);
  assign sw_ctrl_wr  = wr_en && (sel == SEL_SW_CTRL);
  assign tmr_cnt_wr  = wr_en && (sel == SEL_TMR_CNT);
  assign tmr_lim_wr  = wr_en && (sel == SEL_TMR_LIM);
  assign tmr_ctrl_wr = wr_en && (sel == SEL_TMR_CTRL);
  assign key_data_rd = rd_en && (sel == SEL_KEY_DATA); // clears key ready
  assign sw_data_rd  = rd_en && (sel == SEL_SW_DATA);

  // --------------------
  // read path
  // --------------------
  always_comb begin
    case (sel)
      SEL_HEX:      rd_value = DW'(hex_value);
      SEL_LED:      rd_value = DW'(led_value);
      SEL_KEY_DATA: rd_value = DW'(key_data);
      SEL_KEY_CTRL: rd_value = ctrl_word(key_status);
      SEL_SW_DATA:  rd_value = DW'(sw_data);
      SEL_SW_CTRL:  rd_value = ctrl_word(sw_status);
      SEL_TMR_CNT:  rd_value = tmr_count;
      SEL_TMR_LIM:  rd_value = tmr_limit;
      SEL_TMR_CTRL: rd_value = ctrl_word(tmr_status);
      default:      rd_value = '0;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      rsp_valid <= 1'b0;
    else
      rsp_valid <= rd_en; // one response per read
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      rsp_data <= '0;
    else if (rd_en)
      rsp_data <= rd_value; // value from before this edge
  end

  assign rsp = '{valid: rsp_valid, rdata: rsp_data};

  // --------------------
  // interrupt
  // --------------------
  assign tmr_irq = tmr_status.ready & tmr_status.ie;
  assign key_irq = key_status.ready & key_status.ie;
  assign sw_irq  = sw_status.ready & sw_status.ie;
  assign irq     = tmr_irq | key_irq | sw_irq;

  // fixed priority, timer first
  always_comb begin
    if (tmr_irq)
      irq_id = DEV_TIMER;
    else if (key_irq)
      irq_id = DEV_KEY;
    else
      irq_id = DEV_SW;
  end

endmodule

// File: source/input_port.sv
`timescale 1ns/1ns
`include "io_config.svh"

module input_port #(
  parameter int WIDTH  = 4,
  parameter int SETTLE = 0 // 0 captures on the next edge
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic [WIDTH-1:0]         pin,
  input  logic                     data_rd,
  input  logic                     ctrl_wr,
  input  logic [`IO_DATA_BITS-1:0] wr_data,
  output logic [WIDTH-1:0]         data,
  output io_pkg::dev_status_t      status
);
  import io_pkg::*;

  logic [WIDTH-1:0] cand; // value about to be captured
  logic             capture;

  generate
    if (SETTLE == 0) begin : g_direct
      assign cand    = pin;
      assign capture = (pin != data);
    end else begin : g_debounce
      localparam int CW = $clog2(SETTLE + 1);
      localparam logic [CW-1:0] SETTLE_CNT = CW'(SETTLE);

      logic [WIDTH-1:0] sample;
      logic [CW-1:0]    stable_cnt;

      // --------------------
      // settle filter
      // --------------------
      always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
          sample     <= '0;
          stable_cnt <= '0;
        end else if (pin != sample) begin
          sample     <= pin; // restart on any change
          stable_cnt <= '0;
        end else if (stable_cnt != SETTLE_CNT) begin
          stable_cnt <= stable_cnt + 1'b1; // saturates at SETTLE
        end
      end

      assign cand    = sample;
      assign capture = (stable_cnt == SETTLE_CNT) && (sample != data);
    end
  endgenerate

  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      data <= '0;
    else if (capture)
      data <= cand;
  end

  // ready, overrun and enable
  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      status <= '0;
    else
      status <= status_next(status, capture, data_rd, ctrl_wr, wr_data);
  end

endmodule

// File: source/interval_timer.sv
`timescale 1ns/1ns
`include "io_config.svh"

module interval_timer (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     cnt_wr,
  input  logic                     lim_wr,
  input  logic                     ctrl_wr,
  input  logic [`IO_DATA_BITS-1:0] wr_data,
  output logic [`IO_DATA_BITS-1:0] count,
  output logic [`IO_DATA_BITS-1:0] limit,
  output io_pkg::dev_status_t      status
);
  import io_pkg::*;

  localparam int PRESCALE = `IO_TIMER_PRESCALE;
  localparam int PW       = (PRESCALE > 1) ? $clog2(PRESCALE) : 1;
  localparam logic [PW-1:0] PRESC_LAST = PW'(PRESCALE - 1);

  logic [PW-1:0] presc;
  logic          tick;
  logic          wrap;
  logic          bus_wins;
  logic          evt;

  // --------------------
  // prescaler
  // --------------------
  assign tick = (presc == PRESC_LAST);

  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      presc <= '0;
    else if (tick)
      presc <= '0;
    else
      presc <= presc + 1'b1;
  end

  // limit 0 means free running, no events
  assign wrap     = tick && (limit != '0) && (count >= limit - 1'b1);
  assign bus_wins = cnt_wr | lim_wr; // a bus write beats the tick
  assign evt      = wrap & ~bus_wins;

  // --------------------
  // count and limit
  // --------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      count <= '0;
    end else if (cnt_wr) begin
      count <= wr_data;
    end else if (tick && !lim_wr) begin
      if (wrap)
        count <= '0;
      else
        count <= count + 1'b1;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      limit <= '0;
    else if (lim_wr)
      limit <= wr_data;
  end

  // no data register to read, so ready clears only by reset
  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      status <= '0;
    else
      status <= status_next(status, evt, 1'b0, ctrl_wr, wr_data);
  end

endmodule

// File: source/display_regs.sv
`timescale 1ns/1ns
`include "io_config.svh"

module display_regs (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              led_wr,
  input  logic                              hex_wr,
  input  logic [`IO_DATA_BITS-1:0]          wr_data,
  output logic [`IO_LED_BITS-1:0]           led_value,
  output logic [`IO_HEX_BITS-1:0]           hex_value,
  output logic [`IO_LED_BITS-1:0]           ledr,
  output logic [(`IO_HEX_BITS/4)*7-1:0]     hex_seg
);

  localparam int DIGITS = `IO_HEX_BITS / 4;

  // active low, segment g in bit 6
  function automatic logic [6:0] seg7(input logic [3:0] nib);
    logic [6:0] s;
    case (nib)
      4'h0: s = 7'b1000000;
      4'h1: s = 7'b1111001;
      4'h2: s = 7'b0100100;
      4'h3: s = 7'b0110000;
      4'h4: s = 7'b0011001;
      4'h5: s = 7'b0010010;
      4'h6: s = 7'b0000010;
      4'h7: s = 7'b1111000;
      4'h8: s = 7'b0000000;
      4'h9: s = 7'b0010000;
      4'hA: s = 7'b0001000;
      4'hB: s = 7'b0000011; // lower case b
      4'hC: s = 7'b1000110;
      4'hD: s = 7'b0100001; // lower case d
      4'hE: s = 7'b0000110;
      default: s = 7'b0001110; // F
    endcase
    return s;
  endfunction

  // --------------------
  // registers
  // --------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      led_value <= '0;
    else if (led_wr)
      led_value <= wr_data[`IO_LED_BITS-1:0];
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      hex_value <= '0;
    else if (hex_wr)
      hex_value <= wr_data[`IO_HEX_BITS-1:0];
  end

  assign ledr = led_value;

  // digit 0 in the low bits
  always_comb begin
    for (int d = 0; d < DIGITS; d++) begin
      hex_seg[d*7 +: 7] = seg7(hex_value[d*4 +: 4]);
    end
  end

endmodule

// File: source/io_subsystem.sv
`timescale 1ns/1ns
`include "io_config.svh"

module io_subsystem (
  input  logic                          clk,
  input  logic                          reset,
  input  io_pkg::bus_req_t              req,
  output io_pkg::bus_rsp_t              rsp,
  input  logic [`IO_KEY_BITS-1:0]       key,
  input  logic [`IO_SW_BITS-1:0]        sw,
  output logic [`IO_LED_BITS-1:0]       ledr,
  output logic [(`IO_HEX_BITS/4)*7-1:0] hex_seg,
  output logic                          irq,
  output io_pkg::dev_id_t               irq_id
);
  import io_pkg::*;

  logic [`IO_DATA_BITS-1:0] wr_data;
  logic hex_wr, led_wr;
  logic key_ctrl_wr, sw_ctrl_wr;
  logic tmr_cnt_wr, tmr_lim_wr, tmr_ctrl_wr;
  logic key_data_rd, sw_data_rd;

  logic [`IO_HEX_BITS-1:0]  hex_value;
  logic [`IO_LED_BITS-1:0]  led_value;
  logic [`IO_KEY_BITS-1:0]  key_data;
  logic [`IO_SW_BITS-1:0]   sw_data;
  logic [`IO_DATA_BITS-1:0] tmr_count;
  logic [`IO_DATA_BITS-1:0] tmr_limit;
  dev_status_t key_status, sw_status, tmr_status;

  io_bus_fabric u_fabric (
    .clk, .reset, .req, .rsp, .wr_data,
    .hex_wr, .led_wr, .key_ctrl_wr, .sw_ctrl_wr,
    .tmr_cnt_wr, .tmr_lim_wr, .tmr_ctrl_wr,
    .key_data_rd, .sw_data_rd,
    .hex_value, .led_value, .key_data, .key_status,
    .sw_data, .sw_status, .tmr_count, .tmr_limit, .tmr_status,
    .irq, .irq_id
  );

  // keys capture at once
  input_port #(.WIDTH(`IO_KEY_BITS), .SETTLE(0)) u_key (
    .clk, .reset, .pin(key), .data_rd(key_data_rd), .ctrl_wr(key_ctrl_wr),
    .wr_data, .data(key_data), .status(key_status)
  );

  input_port #(.WIDTH(`IO_SW_BITS), .SETTLE(`IO_SW_SETTLE)) u_sw (
    .clk, .reset, .pin(sw), .data_rd(sw_data_rd), .ctrl_wr(sw_ctrl_wr),
    .wr_data, .data(sw_data), .status(sw_status)
  );

  interval_timer u_timer (
    .clk, .reset, .cnt_wr(tmr_cnt_wr), .lim_wr(tmr_lim_wr), .ctrl_wr(tmr_ctrl_wr),
    .wr_data, .count(tmr_count), .limit(tmr_limit), .status(tmr_status)
  );

  display_regs u_display (
    .clk, .reset, .led_wr, .hex_wr, .wr_data,
    .led_value, .hex_value, .ledr, .hex_seg
  );

endmodule

// File: bench/io_bus_tasks.svh
`ifndef IO_BUS_TASKS_SVH
`define IO_BUS_TASKS_SVH

// --------------------
// expected display
// --------------------
// active low, bit 6 is segment g, index is the digit value
localparam logic [6:0] SEG_TABLE [16] = '{
  7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
  7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
};

localparam int RSP_TIMEOUT = 4; // cycles to wait for a read response

function automatic logic [(`IO_HEX_BITS/4)*7-1:0] expected_hex_seg(
  input logic [`IO_HEX_BITS-1:0] value
);
  logic [(`IO_HEX_BITS/4)*7-1:0] segs;
  for (int d = 0; d < `IO_HEX_BITS / 4; d++) begin
    segs[d*7 +: 7] = SEG_TABLE[value[d*4 +: 4]]; // digit 0 lowest
  end
  return segs;
endfunction

// --------------------
// bus access
// --------------------
task automatic bus_write(input logic [`IO_DATA_BITS-1:0] addr,
                         input logic [`IO_DATA_BITS-1:0] data);
  @(negedge clk);
  req = '{valid: 1'b1, write: 1'b1, addr: addr, wdata: data};
  @(negedge clk);
  req.valid = 1'b0; // write has landed at the edge just passed
endtask

task automatic bus_read(input logic [`IO_DATA_BITS-1:0] addr,
                        output logic [`IO_DATA_BITS-1:0] data);
  int waited;
  waited = 0;
  @(negedge clk);
  req = '{valid: 1'b1, write: 1'b0, addr: addr, wdata: '0};
  @(negedge clk);
  req.valid = 1'b0;
  while (!rsp.valid && waited < RSP_TIMEOUT) begin
    @(negedge clk);
    waited++;
  end
  if (!rsp.valid)
    abort_run($sformatf("no read response for address %h", addr));
  else
    data = rsp.rdata;
endtask

task automatic read_expect(input logic [`IO_DATA_BITS-1:0] addr,
                           input logic [`IO_DATA_BITS-1:0] expected);
  logic [`IO_DATA_BITS-1:0] value;
  bus_read(addr, value);
  check_value(expected, value);
endtask

task automatic wait_cycles(input int n);
  repeat (n) @(negedge clk);
endtask

// poll a control register until its ready bit shows up
task automatic wait_ready(input logic [`IO_DATA_BITS-1:0] addr, input int max_reads,
                          input string what);
  logic [`IO_DATA_BITS-1:0] value;
  int reads;
  value = '0;
  reads = 0;
  while (!value[`IO_CTRL_RDY_BIT] && reads < max_reads) begin
    bus_read(addr, value);
    reads++;
  end
  if (!value[`IO_CTRL_RDY_BIT])
    abort_run($sformatf("%s never set ready after %0d reads", what, reads));
endtask

`endif

// File: bench/io_subsystem_tb.sv
`timescale 1ns/1ns
`include "io_config.svh"

module io_subsystem_tb;
  import io_pkg::*;

  localparam int DW        = `IO_DATA_BITS;
  localparam int TMR_LIMIT = 5;
  localparam int TMR_BOUND = TMR_LIMIT * `IO_TIMER_PRESCALE + `IO_TIMER_PRESCALE;

  // rough length of each test in cycles
  localparam int LEN_RESET   = 10 + 8 * 3;
  localparam int LEN_DISPLAY = 4 * 14 + 8;
  localparam int LEN_KEY     = 20;
  localparam int LEN_SWITCH  = 5 * `IO_SW_SETTLE + 20;
  localparam int LEN_IRQ     = TMR_BOUND + 30;
  localparam int LEN_TOTAL   = LEN_RESET + LEN_DISPLAY + LEN_KEY + LEN_SWITCH + LEN_IRQ;
  localparam int WATCHDOG    = LEN_TOTAL + LEN_TOTAL / 2;

  // mapped registers that stay 0 until written or an input changes
  localparam logic [DW-1:0] ZERO_REGS [8] = '{
    `IO_ADDR_HEX, `IO_ADDR_LEDR, `IO_ADDR_KEY, `IO_ADDR_KEY + `IO_CTRL_OFFSET,
    `IO_ADDR_SW, `IO_ADDR_SW + `IO_CTRL_OFFSET,
    `IO_ADDR_TIMER + `IO_TIMER_LIM_OFFSET, `IO_ADDR_TIMER + `IO_TIMER_CTRL_OFFSET
  };

  logic                          clk = 1'b0;
  logic                          reset;
  bus_req_t                      req;
  bus_rsp_t                      rsp;
  logic [`IO_KEY_BITS-1:0]       key;
  logic [`IO_SW_BITS-1:0]        sw;
  logic [`IO_LED_BITS-1:0]       ledr;
  logic [(`IO_HEX_BITS/4)*7-1:0] hex_seg;
  logic                          irq;
  dev_id_t                       irq_id;

  integer        seed = 32'h9192_a492;
  string         test_name = "none";
  logic [DW-1:0] led_v;
  logic [DW-1:0] hex_v;
  logic [DW-1:0] rnd;
  int            cycles;

  io_subsystem u_dut (
    .clk(clk), .reset(reset), .req(req), .rsp(rsp), .key(key), .sw(sw),
    .ledr(ledr), .hex_seg(hex_seg), .irq(irq), .irq_id(irq_id)
  );

  always #4 clk = ~clk;

  task automatic abort_run(input string why);
    $display("** FAIL **");
    $display("%s", why);
    $fatal(1);
  endtask

  task automatic check_value(input logic [63:0] expected, input logic [63:0] actual);
    assert (actual === expected)
      else abort_run($sformatf("Error %s: expected %h, actual %h", test_name, expected, actual));
  endtask

  `include "io_bus_tasks.svh"

  // one response per read, exactly one cycle later
  response_timing: assert property (@(posedge clk) disable iff (reset)
    rsp.valid == $past(req.valid && !req.write))
    else abort_run("read response strobe out of step with the read requests");

  initial begin
    repeat (WATCHDOG) @(posedge clk);
    abort_run($sformatf("timeout, tests did not finish within %0d cycles", WATCHDOG));
  end

  initial begin
    reset = 1'b1;
    req   = '0;
    key   = '0;
    sw    = '0;
    repeat (10) @(negedge clk);
    reset = 1'b0;

    // --------------------
    test_name = "reset_state";
    check_value(0, irq);
    check_value(0, ledr);
    check_value(expected_hex_seg('0), hex_seg);
    for (int i = 0; i < 8; i++)
      read_expect(ZERO_REGS[i], 0); // timer count runs freely, left out

    // --------------------
    test_name = "display_writes";
    for (int n = 0; n < 4; n++) begin
      led_v = $random(seed);
      hex_v = $random(seed);
      bus_write(`IO_ADDR_LEDR, led_v);
      bus_write(`IO_ADDR_HEX, hex_v);
      check_value(led_v[`IO_LED_BITS-1:0], ledr);
      check_value(expected_hex_seg(hex_v[`IO_HEX_BITS-1:0]), hex_seg);
      read_expect(`IO_ADDR_LEDR, led_v[`IO_LED_BITS-1:0]);
      read_expect(`IO_ADDR_HEX, hex_v[`IO_HEX_BITS-1:0]);
    end
    bus_write(`IO_ADDR_HEX + 32'h4, 32'hFFFF_FFFF); // unmapped, dropped
    read_expect(`IO_ADDR_HEX + 32'h4, 0);

    // --------------------
    test_name = "key_status";
    @(negedge clk);
    key = 4'h5;
    read_expect(`IO_ADDR_KEY + `IO_CTRL_OFFSET, 32'h1); // ready
    @(negedge clk);
    key = 4'hA; // second change before any read
    read_expect(`IO_ADDR_KEY + `IO_CTRL_OFFSET, 32'h3);
    read_expect(`IO_ADDR_KEY, 32'hA);
    read_expect(`IO_ADDR_KEY + `IO_CTRL_OFFSET, 32'h2); // overrun stays
    bus_write(`IO_ADDR_KEY + `IO_CTRL_OFFSET, 32'h0);
    read_expect(`IO_ADDR_KEY + `IO_CTRL_OFFSET, 32'h0);

    // --------------------
    test_name = "switch_debounce";
    rnd = $random(seed);
    rnd[0] = 1'b1; // never equal to the idle value
    @(negedge clk);
    sw = rnd[`IO_SW_BITS-1:0];
    wait_cycles(`IO_SW_SETTLE - 1); // glitch one cycle short of settling
    sw = '0;
    wait_cycles(2 * `IO_SW_SETTLE);
    read_expect(`IO_ADDR_SW, 0);
    read_expect(`IO_ADDR_SW + `IO_CTRL_OFFSET, 0);
    rnd = $random(seed);
    rnd[1] = 1'b1;
    @(negedge clk);
    sw = rnd[`IO_SW_BITS-1:0]; // held from here on
    wait_ready(`IO_ADDR_SW + `IO_CTRL_OFFSET, `IO_SW_SETTLE, "switch port");
    read_expect(`IO_ADDR_SW, rnd[`IO_SW_BITS-1:0]);
    read_expect(`IO_ADDR_SW + `IO_CTRL_OFFSET, 0);

    // --------------------
    test_name = "irq_priority";
    bus_write(`IO_ADDR_KEY + `IO_CTRL_OFFSET, 32'h10);
    @(negedge clk);
    key = 4'h3;
    @(negedge clk);
    check_value(1, irq);
    check_value(DEV_KEY, irq_id);
    bus_write(`IO_ADDR_TIMER + `IO_TIMER_CTRL_OFFSET, 32'h10);
    bus_write(`IO_ADDR_TIMER, 0);
    bus_write(`IO_ADDR_TIMER + `IO_TIMER_LIM_OFFSET, TMR_LIMIT);
    cycles = 0;
    while (!(irq && irq_id == DEV_TIMER) && cycles < TMR_BOUND) begin
      @(negedge clk);
      cycles++;
    end
    if (!(irq && irq_id == DEV_TIMER))
      abort_run($sformatf("timer interrupt missing after %0d cycles", cycles));
    bus_write(`IO_ADDR_TIMER + `IO_TIMER_CTRL_OFFSET, 32'h0); // timer out of the irq
    check_value(1, irq);
    check_value(DEV_KEY, irq_id);
    read_expect(`IO_ADDR_KEY, 32'h3);
    check_value(0, irq); // key read clears the last source

    $display("** PASS **");
    $finish;
  end

endmodule

// File: sim.f
+incdir+source
+incdir+bench
source/io_pkg.sv
source/io_bus_fabric.sv
source/input_port.sv
source/interval_timer.sv
source/display_regs.sv
source/io_subsystem.sv
bench/io_subsystem_tb.sv
